// File: rtl/eeprom_pkg.sv
package eeprom_pkg;

    // bus commands from sequencer to bit engine
    localparam logic [1:0] cmd_start = 2'd0;
    localparam logic [1:0] cmd_stop  = 2'd1;
    localparam logic [1:0] cmd_write = 2'd2;
    localparam logic [1:0] cmd_read  = 2'd3;

    // 24C16 style control byte
    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] block;    // addr[10:8]
        logic       rnw;
    } ctrl_fields_t;

    typedef union packed {
        ctrl_fields_t f;
        logic [7:0]   raw;
    } ctrl_byte_u;

    localparam logic [3:0] dev_code_default = 4'b1010;
    localparam logic [7:0] scl_div_default  = 8'd4;

    localparam logic cfg_sel_div = 1'b0;
    localparam logic cfg_sel_dev = 1'b1;

    // sequencer states
    localparam logic [3:0] st_idle    = 4'd0;
    localparam logic [3:0] st_start   = 4'd1;
    localparam logic [3:0] st_ctrl_w  = 4'd2;
    localparam logic [3:0] st_addr    = 4'd3;
    localparam logic [3:0] st_data_w  = 4'd4;
    localparam logic [3:0] st_restart = 4'd5;
    localparam logic [3:0] st_ctrl_r  = 4'd6;
    localparam logic [3:0] st_data_r  = 4'd7;
    localparam logic [3:0] st_stop    = 4'd8;
    localparam logic [3:0] st_done    = 4'd9;

endpackage

// File: rtl/eeprom_cfg_regs.sv
`timescale 1ns/1ps

module eeprom_cfg_regs (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cfg_wr,
    input  logic       cfg_sel,
    input  logic [7:0] cfg_wdata,
    input  logic       busy,
    output logic [7:0] scl_div,
    output logic [3:0] dev_code
);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_div  <= eeprom_pkg::scl_div_default;
            dev_code <= eeprom_pkg::dev_code_default;
        end
        else if (cfg_wr && !busy) // no changes mid transfer
        begin
            case (cfg_sel)
                eeprom_pkg::cfg_sel_div: scl_div  <= cfg_wdata;
                eeprom_pkg::cfg_sel_dev: dev_code <= cfg_wdata[3:0];
                default: ;
            endcase
        end
    end

    // control byte must see one device code for the whole transaction
    a_dev_stable: assert property (@(posedge CLK) disable iff (RESET)
        busy |=> $stable(dev_code));

endmodule

// File: rtl/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic       CLK,
    input  logic       RESET,
    input  logic [7:0] scl_div,
    input  logic [1:0] cmd,
    input  logic       cmd_go,
    input  logic [7:0] tx_byte,
    input  logic       master_nack,
    output logic       cmd_done,
    output logic [7:0] rx_byte,
    output logic       slave_ack,
    output logic       scl,
    output logic       sda_low,
    input  logic       sda_in
);

    logic       running;
    logic [1:0] cmd_r;
    logic [7:0] tx_r;
    logic [7:0] div_cnt;  // cycles within a quarter
    logic [1:0] quarter;
    logic [3:0] bit_cnt;  // 8 is the ack bit
    logic       tick;
    logic       data_cmd;
    logic       last_bit;

    assign tick     = running && (div_cnt == scl_div);
    assign data_cmd = (cmd_r == eeprom_pkg::cmd_write) || (cmd_r == eeprom_pkg::cmd_read);
    assign last_bit = !data_cmd || (bit_cnt == 4'd8);

    // sda level for the first quarter while scl is low
    function automatic logic first_sda(input logic [1:0] c, input logic [3:0] b,
                                       input logic [7:0] d, input logic nack);
        logic pull;
        case (c)
            eeprom_pkg::cmd_start: pull = 1'b0;  // falls later in the period
            eeprom_pkg::cmd_stop:  pull = 1'b1;
            eeprom_pkg::cmd_write: pull = (b == 4'd8) ? 1'b0 : !d[3'd7 - b[2:0]];
            default:               pull = (b == 4'd8) ? !nack : 1'b0;
        endcase
        return pull;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            running   <= 1'b0;
            cmd_r     <= eeprom_pkg::cmd_start;
            cmd_done  <= 1'b0;
            slave_ack <= 1'b0;
            scl       <= 1'b1;
            sda_low   <= 1'b0;
            div_cnt   <= '0;
            quarter   <= '0;
            bit_cnt   <= '0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (cmd_go)
            begin
                running <= 1'b1;
                cmd_r   <= cmd;
                div_cnt <= '0;
                quarter <= '0;
                bit_cnt <= '0;
                scl     <= 1'b0;
                sda_low <= first_sda(cmd, 4'd0, tx_byte, master_nack);
            end
            else if (running)
            begin
                if (!tick)
                    div_cnt <= div_cnt + 8'd1;
                else
                begin
                    div_cnt <= '0;
                    quarter <= quarter + 2'd1;
                    case (quarter)
                        2'd0: scl <= 1'b1;
                        2'd1:
                        begin
                            // middle of scl high
                            if (cmd_r == eeprom_pkg::cmd_start)
                                sda_low <= 1'b1;
                            else if (cmd_r == eeprom_pkg::cmd_stop)
                                sda_low <= 1'b0;
                            else if (cmd_r == eeprom_pkg::cmd_write && bit_cnt == 4'd8)
                                slave_ack <= !sda_in;
                        end
                        2'd2: scl <= (cmd_r == eeprom_pkg::cmd_stop); // stop leaves scl high
                        default:
                        begin
                            if (last_bit)
                            begin
                                running  <= 1'b0;
                                cmd_done <= 1'b1;
                            end
                            else
                            begin
                                bit_cnt <= bit_cnt + 4'd1;
                                sda_low <= first_sda(cmd_r, bit_cnt + 4'd1, tx_r, master_nack);
                            end
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_go)
            tx_r <= tx_byte;
        if (tick && quarter == 2'd1 && cmd_r == eeprom_pkg::cmd_read && bit_cnt != 4'd8)
            rx_byte <= {rx_byte[6:0], sda_in}; // msb first
    end

    // sequencer waits for cmd_done before the next command
    a_go_idle: assert property (@(posedge CLK) disable iff (RESET)
        cmd_go |-> !running);

    a_sda_hold: assert property (@(posedge CLK) disable iff (RESET)
        (running && data_cmd && scl && $past(scl)) |-> $stable(sda_low));

endmodule

// File: rtl/eeprom_sequencer.sv
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    input  logic [3:0]  dev_code,
    output logic [7:0]  rdata,
    output logic        ack,
    output logic        busy,
    output logic        nack_err,
    output logic [1:0]  cmd,
    output logic        cmd_go,
    output logic [7:0]  tx_byte,
    output logic        master_nack,
    input  logic        cmd_done,
    input  logic [7:0]  rx_byte,
    input  logic        slave_ack
);

    logic [3:0]             state;
    logic [3:0]             next_state;
    logic                   issued;   // cmd_go sent for this state
    logic                   is_read;
    logic [10:0]            addr_r;
    logic [7:0]             wdata_r;
    eeprom_pkg::ctrl_byte_u ctrl;

    always_comb
    begin
        ctrl.f.dev_code = dev_code;
        ctrl.f.block    = addr_r[10:8];
        ctrl.f.rnw      = (state == eeprom_pkg::st_ctrl_r);
        case (state)
            eeprom_pkg::st_addr:   tx_byte = addr_r[7:0];
            eeprom_pkg::st_data_w: tx_byte = wdata_r;
            default:               tx_byte = ctrl.raw;
        endcase
        case (state)
            eeprom_pkg::st_start, eeprom_pkg::st_restart: cmd = eeprom_pkg::cmd_start;
            eeprom_pkg::st_stop:                          cmd = eeprom_pkg::cmd_stop;
            eeprom_pkg::st_data_r:                        cmd = eeprom_pkg::cmd_read;
            default:                                      cmd = eeprom_pkg::cmd_write;
        endcase
    end

    // the only read byte gets a nack
    assign master_nack = (state == eeprom_pkg::st_data_r);

    always_comb
    begin
        case (state)
            eeprom_pkg::st_start:   next_state = eeprom_pkg::st_ctrl_w;
            eeprom_pkg::st_ctrl_w:  next_state = eeprom_pkg::st_addr;
            eeprom_pkg::st_addr:    next_state = is_read ? eeprom_pkg::st_restart
                                                         : eeprom_pkg::st_data_w;
            eeprom_pkg::st_data_w:  next_state = eeprom_pkg::st_stop;
            eeprom_pkg::st_restart: next_state = eeprom_pkg::st_ctrl_r;
            eeprom_pkg::st_ctrl_r:  next_state = eeprom_pkg::st_data_r;
            eeprom_pkg::st_data_r:  next_state = eeprom_pkg::st_stop;
            eeprom_pkg::st_stop:    next_state = eeprom_pkg::st_done;
            default:                next_state = eeprom_pkg::st_idle;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= eeprom_pkg::st_idle;
            issued   <= 1'b0;
            is_read  <= 1'b0;
            cmd_go   <= 1'b0;
            ack      <= 1'b0;
            busy     <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            cmd_go <= 1'b0;
            ack    <= 1'b0;
            case (state)
                eeprom_pkg::st_idle:
                    if (wr || rd)
                    begin
                        is_read  <= !wr; // wr wins
                        busy     <= 1'b1;
                        nack_err <= 1'b0;
                        state    <= eeprom_pkg::st_start;
                    end
                eeprom_pkg::st_done:
                begin
                    ack   <= 1'b1;
                    busy  <= 1'b0;
                    state <= eeprom_pkg::st_idle;
                end
                default:
                    if (!issued)
                    begin
                        cmd_go <= 1'b1;
                        issued <= 1'b1;
                    end
                    else if (cmd_done)
                    begin
                        issued <= 1'b0;
                        if (cmd == eeprom_pkg::cmd_write && !slave_ack)
                        begin
                            nack_err <= 1'b1;  // abort straight to stop
                            state    <= eeprom_pkg::st_stop;
                        end
                        else
                            state <= next_state;
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::st_idle && (wr || rd))
        begin
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (state == eeprom_pkg::st_data_r && cmd_done)
            rdata <= rx_byte;
    end

    a_ack_no_go: assert property (@(posedge CLK) disable iff (RESET)
        !(ack && cmd_go));

endmodule

// File: rtl/eeprom_i2c_top.sv
`timescale 1ns/1ps

module eeprom_i2c_top (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    input  logic        cfg_wr,
    input  logic        cfg_sel,
    input  logic [7:0]  cfg_wdata,
    input  logic        sda_in,
    output logic [7:0]  rdata,
    output logic        ack,
    output logic        busy,
    output logic        nack_err,
    output logic        scl,
    output logic        sda_low   // high pulls sda down
);

    logic [7:0] scl_div;
    logic [3:0] dev_code;
    logic [1:0] cmd;
    logic       cmd_go;
    logic [7:0] tx_byte;
    logic       master_nack;
    logic       cmd_done;
    logic [7:0] rx_byte;
    logic       slave_ack;

    eeprom_cfg_regs i_cfg (
        .CLK       (CLK),
        .RESET     (RESET),
        .cfg_wr    (cfg_wr),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .busy      (busy),
        .scl_div   (scl_div),
        .dev_code  (dev_code)
    );

    eeprom_sequencer i_seq (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .dev_code    (dev_code),
        .rdata       (rdata),
        .ack         (ack),
        .busy        (busy),
        .nack_err    (nack_err),
        .cmd         (cmd),
        .cmd_go      (cmd_go),
        .tx_byte     (tx_byte),
        .master_nack (master_nack),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .slave_ack   (slave_ack)
    );

    i2c_bit_engine i_bit (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl_div     (scl_div),
        .cmd         (cmd),
        .cmd_go      (cmd_go),
        .tx_byte     (tx_byte),
        .master_nack (master_nack),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .slave_ack   (slave_ack),
        .scl         (scl),
        .sda_low     (sda_low),
        .sda_in      (sda_in)
    );

endmodule

// File: test/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    output logic sda_pull
);

    localparam logic [3:0] dev_code = 4'b1010;
    localparam int ph_idle  = 0;
    localparam int ph_ctrl  = 1;
    localparam int ph_addr  = 2;
    localparam int ph_wdata = 3;
    localparam int ph_rdata = 4;

    logic [7:0] mem [0:2047];
    logic [7:0] shift;
    logic [7:0] rd_byte;
    logic [7:0] word;
    logic [2:0] block;
    logic       scl_q;
    logic       sda_q;
    int         phase;
    int         next_phase;
    int         bit_cnt;
    int         rd_cnt;

    initial
    begin
        // fill depends on block and word
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ {3'(i >> 8), 5'd0};
        sda_pull   = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        phase      = ph_idle;
        next_phase = ph_idle;
        bit_cnt    = 0;
        rd_cnt     = 0;
        block      = 3'd0;
        word       = 8'd0;
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl && scl_q && sda != sda_q)
        begin
            // falling sda starts and rising sda stops
            phase    = sda ? ph_idle : ph_ctrl;
            bit_cnt  = 0;
            sda_pull = 1'b0;
        end
        else if (scl && !scl_q)
        begin
            if (phase != ph_idle && phase != ph_rdata && bit_cnt < 8)
            begin
                shift   = {shift[6:0], sda};  // msb first
                bit_cnt = bit_cnt + 1;
            end
        end
        else if (!scl && scl_q)
        begin
            if (phase == ph_rdata)
            begin
                if (rd_cnt < 8)
                begin
                    rd_byte  = rd_byte << 1;
                    sda_pull = !rd_byte[7];
                    rd_cnt   = rd_cnt + 1;
                end
                else if (rd_cnt == 8)
                begin
                    sda_pull = 1'b0;  // master ack slot
                    rd_cnt   = 9;
                end
                else
                    phase = ph_idle;
            end
            else if (phase != ph_idle && bit_cnt == 8)
            begin
                case (phase)
                    ph_ctrl:
                    begin
                        block      = shift[3:1];
                        sda_pull   = (shift[7:4] == dev_code);
                        next_phase = !sda_pull ? ph_idle : (shift[0] ? ph_rdata : ph_addr);
                    end
                    ph_addr:
                    begin
                        word       = shift;
                        sda_pull   = 1'b1;
                        next_phase = ph_wdata;
                    end
                    default:
                    begin
                        mem[{block, word}] = shift;
                        sda_pull           = 1'b1;
                        next_phase         = ph_idle;
                    end
                endcase
                bit_cnt = 9;
            end
            else if (phase != ph_idle && bit_cnt == 9)
            begin
                sda_pull = 1'b0;
                bit_cnt  = 0;
                phase    = next_phase;
                if (phase == ph_rdata)
                begin
                    rd_byte  = mem[{block, word}];
                    sda_pull = !rd_byte[7];
                    rd_cnt   = 1;
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: test/tb_eeprom_i2c.sv
`timescale 1ns/1ps

module tb_eeprom_i2c;

    localparam int num_vectors    = 21;
    localparam int num_cols       = 6;
    localparam int clk_period     = 100;
    localparam int drive_delay    = 10;
    localparam int timeout_cycles = num_vectors * 40 * 4 * 256;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic        cfg_wr;
    logic        cfg_sel;
    logic [7:0]  cfg_wdata;
    logic [7:0]  rdata;
    logic        ack;
    logic        busy;
    logic        nack_err;
    logic        scl;
    logic        sda_low;
    logic        sda_pull;
    logic        sda;

    logic [15:0] vectors [0:num_vectors*num_cols-1];
    integer      seed = 32'hf069_379e;
    int          errors = 0;
    int          accepted = 0;
    int          ack_cnt = 0;
    int          cycle_cnt = 0;

    assign sda = !(sda_low || sda_pull);  // wired and

    eeprom_i2c_top i_dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .cfg_wr    (cfg_wr),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .sda_in    (sda),
        .rdata     (rdata),
        .ack       (ack),
        .busy      (busy),
        .nack_err  (nack_err),
        .scl       (scl),
        .sda_low   (sda_low)
    );

    eeprom_model i_eeprom (
        .scl      (scl),
        .sda      (sda),
        .sda_pull (sda_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(clk_period / 2) CLK = ~CLK;
    end

    always @(posedge CLK)
        cycle_cnt <= cycle_cnt + 1;

    always @(negedge CLK)
        if (ack)
            ack_cnt <= ack_cnt + 1;

    initial
    begin
        while (cycle_cnt < timeout_cycles)
            @(posedge CLK);
        $display("Timeout: the run did not end within %0d clock cycles", timeout_cycles);
        $display("Finished with errors");
        $finish;
    end

    task automatic step_cycle();
        @(posedge CLK);
        #(drive_delay);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got !== exp)
        begin
            $display("Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic config_write(input logic sel, input logic [7:0] value);
        cfg_wr    = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = value;
        step_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic run_transaction(input logic [1:0] op, input logic [10:0] a,
                                   input logic [7:0] d, input logic [7:0] div,
                                   input logic [7:0] exp_rdata, input logic exp_nack);
        int   cycles;
        int   rises;
        int   t_rise;
        int   period;
        int   junk;
        logic scl_prev;
        cycles = 0;
        rises  = 0;
        t_rise = 0;
        period = -1;
        addr   = a;
        wdata  = d;
        wr     = (op != 2'd1);
        rd     = (op != 2'd0);  // op 3 raises both
        step_cycle();
        wr = 1'b0;
        rd = 1'b0;
        accepted++;
        check_value("busy", int'(busy), 1);
        scl_prev = scl;
        while (!ack)
        begin
            step_cycle();
            cycles++;
            if (cycles == 3)
            begin
                // requests while busy must be dropped
                check_value("busy", int'(busy), 1);
                junk      = $random(seed);
                wr        = 1'b1;
                rd        = 1'b1;
                cfg_wr    = 1'b1;
                cfg_sel   = junk[0];
                cfg_wdata = 8'h33;
            end
            else
            begin
                wr     = 1'b0;
                rd     = 1'b0;
                cfg_wr = 1'b0;
            end
            if (scl && !scl_prev)
            begin
                rises++;
                if (rises == 2)
                    t_rise = cycles;
                if (rises == 3)
                    period = cycles - t_rise;  // bits 0 and 1 of control byte
            end
            scl_prev = scl;
        end
        check_value("busy", int'(busy), 0);
        check_value("nack_err", int'(nack_err), int'(exp_nack));
        if (op == 2'd1)
            check_value("rdata", int'(rdata), int'(exp_rdata));
        check_value("scl period", period, 4 * (int'(div) + 1));
    endtask

    initial
    begin
        int         gap;
        int         base;
        logic [1:0] op;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = '0;
        cfg_wr    = 1'b0;
        cfg_sel   = 1'b0;
        cfg_wdata = '0;
        $readmemh("test/eeprom_vectors.txt", vectors);
        repeat (8) @(posedge CLK);
        #(drive_delay);
        RESET = 1'b0;
        check_value("scl", int'(scl), 1);
        check_value("sda_low", int'(sda_low), 0);
        check_value("busy", int'(busy), 0);
        check_value("ack", int'(ack), 0);
        check_value("nack_err", int'(nack_err), 0);
        for (int i = 0; i < num_vectors; i++)
        begin
            base = i * num_cols;
            op   = vectors[base][1:0];
            gap  = ($random(seed) & 7) + 1;
            repeat (gap) step_cycle();
            check_value("ack count", ack_cnt, accepted);
            check_value("busy", int'(busy), 0);
            if (op == 2'd2)
                config_write(eeprom_pkg::cfg_sel_dev, vectors[base+2][7:0]);
            else
            begin
                config_write(eeprom_pkg::cfg_sel_div, vectors[base+3][7:0]);
                run_transaction(op, vectors[base+1][10:0], vectors[base+2][7:0],
                                vectors[base+3][7:0], vectors[base+4][7:0],
                                vectors[base+5][0]);
            end
        end
        repeat (8) step_cycle();
        check_value("ack count", ack_cnt, accepted);
        $display("errors: %0d, transactions: %0d", errors, accepted);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: eeprom_i2c.f
rtl/eeprom_pkg.sv
rtl/eeprom_cfg_regs.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_sequencer.sv
rtl/eeprom_i2c_top.sv
test/eeprom_model.sv
test/tb_eeprom_i2c.sv

// File: run_sim.sh
#!/bin/bash

cd "$(dirname "$0")" || exit 1

top=tb_eeprom_i2c
log=sim.log

verilator --binary --timing --assert --top-module "$top" -f eeprom_i2c.f -o "$top"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$log"; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation PASSED"
exit 0

// File: test/eeprom_vectors.txt
// op addr wdata scl_div exp_rdata exp_nack, all hex
// op 0 write, 1 read, 2 set device code to wdata, 3 write with rd also high
0 005 3c 01 00 0
1 005 00 01 3c 0
0 1a7 81 00 00 0
1 1a7 00 02 81 0
3 2f0 5e 04 00 0
1 2f0 00 04 5e 0
0 3c4 e7 09 00 0
0 412 69 02 00 0
0 555 aa 01 00 0
0 6ee 17 00 00 0
0 7ff c3 03 00 0
1 3c4 00 01 e7 0
1 412 00 00 69 0
1 555 00 09 aa 0
1 6ee 00 02 17 0
1 7ff 00 01 c3 0
1 5a3 00 01 03 0
2 000 05 00 00 0
0 005 99 01 00 1
2 000 0a 00 00 0
1 005 00 01 3c 0
